// File: include/systolicCfg.svh
`ifndef SYSTOLIC_CFG_SVH
`define SYSTOLIC_CFG_SVH

// Link framing
`define NIBBLE_W  4
`define BLOCK_LEN 4   // Cycles per block, one nibble each
`define CNT_W     2   // Block counter width

// Address field of a control word
`define ADDR_PASS   2'd0
`define ADDR_OPER   2'd1   // A0 A1 on column, B0 B1 on row
`define ADDR_LOAD01 2'd2   // C0 on column, C1 on row
`define ADDR_LOAD23 2'd3   // C2 on column, C3 on row

`endif

// File: design/systolicPkg.sv
`include "systolicCfg.svh"

package systolicPkg;

    // One link nibble and one full link word
    typedef logic [`NIBBLE_W-1:0] nibble_t;
    typedef logic [`NIBBLE_W*`BLOCK_LEN-1:0] word_t;

    typedef logic [7:0] fp8_t;    // E5M2 operand
    typedef logic [15:0] fp16_t;  // Half precision product

    // One control bit per cycle of a block
    typedef logic [`BLOCK_LEN-1:0] ctrl_t;
    typedef logic [1:0] addr_t;

    // Values follow the block counter
    typedef enum logic [`CNT_W-1:0] {
        PH_LOAD0,
        PH_LOAD1,
        PH_LOAD2,
        PH_LAST
    } phase_e;

endpackage

// File: design/frameIf.sv
`timescale 1ns/1ps

interface frameIf;
    import systolicPkg::*;

    // Live assembled words, valid as a whole in the last phase
    word_t colWord;
    word_t rowWord;
    ctrl_t colCtrl;
    ctrl_t rowCtrl;

    modport producer (
        output colWord,
        output rowWord,
        output colCtrl,
        output rowCtrl
    );

    modport consumer (
        input colWord,
        input rowWord,
        input colCtrl,
        input rowCtrl
    );
endinterface

// File: design/cellControl.sv
`timescale 1ns/1ps
`include "systolicCfg.svh"

module cellControl (
    input  logic                clk,
    input  logic                rst_n,
    frameIf.consumer            frame,
    frameIf.consumer            fwdFrame,
    output systolicPkg::phase_e phase,
    output systolicPkg::addr_t  colLoad,
    output systolicPkg::addr_t  rowLoad,
    output logic                save
);
    import systolicPkg::*;

    logic [`CNT_W-1:0] blockCnt;
    addr_t fwdColAddr;
    addr_t fwdRowAddr;

    // Free running, wraps every block
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            blockCnt <= '0;
        end else begin
            blockCnt <= blockCnt + 1'b1;
        end
    end

    assign phase = phase_e'(blockCnt);

    // Address sits in the top two control bits
    assign colLoad = frame.colCtrl[$bits(ctrl_t)-1 -: $bits(addr_t)];
    assign rowLoad = frame.rowCtrl[$bits(ctrl_t)-1 -: $bits(addr_t)];
    assign fwdColAddr = fwdFrame.colCtrl[$bits(ctrl_t)-1 -: $bits(addr_t)];
    assign fwdRowAddr = fwdFrame.rowCtrl[$bits(ctrl_t)-1 -: $bits(addr_t)];

    // Phases 2 and 3 multiply live operands, phases 0 and 1 the previous block
    always_comb begin
        if (phase == PH_LOAD2 || phase == PH_LAST) begin
            save = (colLoad == `ADDR_OPER) && (rowLoad == `ADDR_OPER);
        end else begin
            save = (fwdColAddr == `ADDR_OPER) && (fwdRowAddr == `ADDR_OPER);
        end
    end

    // Block boundaries never slip
    assert property (@(posedge clk) $past(rst_n) |-> blockCnt == $past(blockCnt) + 1'b1)
        else $error("block counter did not advance by one");

endmodule

// File: design/nibblePort.sv
`timescale 1ns/1ps
`include "systolicCfg.svh"

module nibblePort (
    input  logic                 clk,
    input  logic                 rst_n,
    input  systolicPkg::nibble_t colIn,
    input  systolicPkg::nibble_t rowIn,
    input  logic                 colCtrlIn,
    input  logic                 rowCtrlIn,
    input  systolicPkg::phase_e  phase,
    input  systolicPkg::addr_t   colLoad,
    input  systolicPkg::addr_t   rowLoad,
    input  systolicPkg::word_t   acc0,
    input  systolicPkg::word_t   acc1,
    input  systolicPkg::word_t   acc2,
    input  systolicPkg::word_t   acc3,
    frameIf.producer             frame,
    frameIf.producer             fwdFrame,
    output systolicPkg::nibble_t colOut,
    output systolicPkg::nibble_t rowOut,
    output logic                 colCtrlOut,
    output logic                 rowCtrlOut
);
    import systolicPkg::*;

    logic [(`BLOCK_LEN-1)*`NIBBLE_W-1:0] colBuf;  // First three nibbles
    logic [(`BLOCK_LEN-1)*`NIBBLE_W-1:0] rowBuf;
    logic [`BLOCK_LEN-2:0] colCtrlBuf;
    logic [`BLOCK_LEN-2:0] rowCtrlBuf;
    word_t colLive;
    word_t rowLive;
    ctrl_t colCtrlLive;
    ctrl_t rowCtrlLive;
    word_t colFwd;   // Word going out during the next block
    word_t rowFwd;
    ctrl_t colCtrlFwd;
    ctrl_t rowCtrlFwd;
    word_t colSel;
    word_t rowSel;
    ctrl_t colCtrlSel;
    ctrl_t rowCtrlSel;

    // Nibble k goes to slot k counted from the top, MSB first
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            colBuf <= '0;
            rowBuf <= '0;
            colCtrlBuf <= '0;
            rowCtrlBuf <= '0;
        end else begin
            for (int k = 0; k < `BLOCK_LEN - 1; k++) begin
                if (phase == phase_e'(k)) begin
                    colBuf[(`BLOCK_LEN-2-k)*`NIBBLE_W +: `NIBBLE_W] <= colIn;
                    rowBuf[(`BLOCK_LEN-2-k)*`NIBBLE_W +: `NIBBLE_W] <= rowIn;
                    colCtrlBuf[`BLOCK_LEN-2-k] <= colCtrlIn;
                    rowCtrlBuf[`BLOCK_LEN-2-k] <= rowCtrlIn;
                end
            end
        end
    end

    assign colLive = {colBuf, colIn};
    assign rowLive = {rowBuf, rowIn};
    assign colCtrlLive = {colCtrlBuf, colCtrlIn};
    assign rowCtrlLive = {rowCtrlBuf, rowCtrlIn};

    assign frame.colWord = colLive;
    assign frame.rowWord = rowLive;
    assign frame.colCtrl = colCtrlLive;
    assign frame.rowCtrl = rowCtrlLive;

    // Load blocks swap in the old accumulator value
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            colFwd <= '0;
            rowFwd <= '0;
            colCtrlFwd <= '0;
            rowCtrlFwd <= '0;
        end else if (phase == PH_LAST) begin
            case (colLoad)
                `ADDR_LOAD01: colFwd <= acc0;
                `ADDR_LOAD23: colFwd <= acc2;
                `ADDR_PASS, `ADDR_OPER: colFwd <= colLive;
            endcase
            case (rowLoad)
                `ADDR_LOAD01: rowFwd <= acc1;
                `ADDR_LOAD23: rowFwd <= acc3;
                `ADDR_PASS, `ADDR_OPER: rowFwd <= rowLive;
            endcase
            colCtrlFwd <= colCtrlLive;  // Control words pass unchanged
            rowCtrlFwd <= rowCtrlLive;
        end
    end

    assign fwdFrame.colWord = colFwd;
    assign fwdFrame.rowWord = rowFwd;
    assign fwdFrame.colCtrl = colCtrlFwd;
    assign fwdFrame.rowCtrl = rowCtrlFwd;

    // Phase k brings nibble k to the top
    assign colSel = colFwd << (`NIBBLE_W * phase);
    assign rowSel = rowFwd << (`NIBBLE_W * phase);
    assign colCtrlSel = colCtrlFwd << phase;
    assign rowCtrlSel = rowCtrlFwd << phase;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            colOut <= '0;
            rowOut <= '0;
            colCtrlOut <= 1'b0;
            rowCtrlOut <= 1'b0;
        end else begin
            colOut <= colSel[$bits(word_t)-1 -: `NIBBLE_W];
            rowOut <= rowSel[$bits(word_t)-1 -: `NIBBLE_W];
            colCtrlOut <= colCtrlSel[$bits(ctrl_t)-1];
            rowCtrlOut <= rowCtrlSel[$bits(ctrl_t)-1];
        end
    end

endmodule

// File: design/fp8Multiplier.sv
`timescale 1ns/1ps

module fp8Multiplier (
    input  systolicPkg::fp8_t  a,
    input  systolicPkg::fp8_t  b,
    output systolicPkg::fp16_t product
);
    import systolicPkg::*;

    logic sign;
    logic [4:0] expA;
    logic [4:0] expB;
    logic nanA;
    logic nanB;
    logic infA;
    logic infB;
    logic zeroA;
    logic zeroB;
    logic [2:0] sigA;      // Hidden bit plus two mantissa bits
    logic [2:0] sigB;
    logic [5:0] sigProd;   // 1.0 sits at bit 4
    logic [2:0] lead;
    logic [5:0] norm;      // Leading one moved to bit 5
    logic signed [6:0] expN;
    logic [3:0] shift;
    logic [23:0] wide;
    logic [10:0] kept;
    logic guardBit;
    logic stickyBit;
    logic [10:0] rounded;
    logic [4:0] expOut;

    assign sign = a[7] ^ b[7];

    // Classify operands
    assign nanA = (a[6:2] == 5'h1F) && (a[1:0] != 2'd0);
    assign nanB = (b[6:2] == 5'h1F) && (b[1:0] != 2'd0);
    assign infA = (a[6:2] == 5'h1F) && (a[1:0] == 2'd0);
    assign infB = (b[6:2] == 5'h1F) && (b[1:0] == 2'd0);
    assign zeroA = (a[6:2] == 5'd0) && (a[1:0] == 2'd0);
    assign zeroB = (b[6:2] == 5'd0) && (b[1:0] == 2'd0);

    // Subnormals use exponent 1 without the hidden bit
    assign expA = (a[6:2] == 5'd0) ? 5'd1 : a[6:2];
    assign expB = (b[6:2] == 5'd0) ? 5'd1 : b[6:2];
    assign sigA = {a[6:2] != 5'd0, a[1:0]};
    assign sigB = {b[6:2] != 5'd0, b[1:0]};
    assign sigProd = sigA * sigB;

    always_comb begin
        lead = 3'd0;
        for (int i = 0; i < 6; i++) begin
            if (sigProd[i]) begin
                lead = 3'(i);
            end
        end
    end

    assign norm = sigProd << (3'd5 - lead);

    // Rebias from two E5M2 exponents to half precision
    assign expN = $signed({2'b00, expA}) + $signed({2'b00, expB})
                + $signed({4'b0000, lead}) - 7'sd19;

    // Subnormal results shift right, no bits fall off the bottom
    assign shift = (expN > 7'sd0) ? 4'd0 : 4'(7'sd1 - expN);
    assign wide = {norm, 18'd0} >> shift;
    assign kept = wide[23:13];
    assign guardBit = wide[12];
    assign stickyBit = |wide[11:0];

    // Round to nearest, ties to even
    assign rounded = (guardBit && (stickyBit || kept[0])) ? kept + 11'd1 : kept;

    // Rounding up can carry a subnormal into the smallest normal
    assign expOut = !rounded[10] ? 5'd0 : (expN > 7'sd0) ? expN[4:0] : 5'd1;

    always_comb begin
        if (nanA || nanB || (infA && zeroB) || (zeroA && infB)) begin
            product = {sign, 5'h1F, 10'd1};   // Canonical NaN
        end else if (infA || infB) begin
            product = {sign, 5'h1F, 10'd0};
        end else if (zeroA || zeroB) begin
            product = {sign, 15'd0};
        end else if (expN >= 7'sd31) begin
            product = {sign, 5'h1F, 10'd0};   // Overflow
        end else if (expN < -7'sd10) begin
            product = {sign, 15'd0};          // Below half the smallest subnormal
        end else begin
            product = {sign, expOut, rounded[9:0]};
        end
    end

endmodule

// File: design/productPipeline.sv
`timescale 1ns/1ps

module productPipeline (
    input  logic                clk,
    input  logic                rst_n,
    input  systolicPkg::phase_e phase,
    input  logic                save,
    frameIf.consumer            frame,
    frameIf.consumer            fwdFrame,
    input  systolicPkg::word_t  acc0,
    input  systolicPkg::word_t  acc1,
    input  systolicPkg::word_t  acc2,
    input  systolicPkg::word_t  acc3,
    output systolicPkg::word_t  mergedWord,
    output logic                mergeValid
);
    import systolicPkg::*;

    fp8_t opA;
    fp8_t opB;
    word_t accSel;
    fp16_t product;
    fp16_t prodS0;        // Product register
    word_t accS0;
    logic saveS0;
    logic [7:0] prodS1;   // Product bits 9..6 and 3..0
    word_t accS1;
    logic saveS1;
    logic [3:0] prodS2;   // Product bits 7..6 and 1..0
    word_t accS2;
    logic saveS2;

    // Two product bits into each byte of the accumulator
    function automatic word_t sliceMask(input logic [1:0] hiBits, input logic [1:0] loBits,
                                        input int pos);
        word_t mask;
        mask = '0;
        mask[pos+8 +: 2] = hiBits;
        mask[pos +: 2] = loBits;
        return mask;
    endfunction

    // A0 A1 in the high and low column bytes, B0 B1 likewise on the row
    always_comb begin
        case (phase)
            PH_LOAD2: begin
                opA = frame.colWord[15:8];
                opB = frame.rowWord[15:8];
                accSel = acc0;
            end
            PH_LAST: begin
                opA = frame.colWord[7:0];
                opB = frame.rowWord[15:8];
                accSel = acc1;
            end
            PH_LOAD0: begin
                opA = fwdFrame.colWord[15:8];
                opB = fwdFrame.rowWord[7:0];
                accSel = acc2;
            end
            default: begin
                opA = fwdFrame.colWord[7:0];
                opB = fwdFrame.rowWord[7:0];
                accSel = acc3;
            end
        endcase
    end

    fp8Multiplier mult (
        .a      (opA),
        .b      (opB),
        .product(product)
    );

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            prodS0 <= '0;
            accS0 <= '0;
            saveS0 <= 1'b0;
            prodS1 <= '0;
            accS1 <= '0;
            saveS1 <= 1'b0;
            prodS2 <= '0;
            accS2 <= '0;
            saveS2 <= 1'b0;
        end else begin
            prodS0 <= product;
            accS0 <= accSel;
            saveS0 <= save;
            accS1 <= accS0 ^ sliceMask(prodS0[11:10], prodS0[5:4], 4);
            prodS1 <= {prodS0[9:6], prodS0[3:0]};
            saveS1 <= saveS0;
            accS2 <= accS1 ^ sliceMask(prodS1[7:6], prodS1[3:2], 2);
            prodS2 <= {prodS1[5:4], prodS1[1:0]};
            saveS2 <= saveS1;
        end
    end

    // Last slice stays combinational into the accumulator write
    assign mergedWord = accS2 ^ sliceMask(prodS2[3:2], prodS2[1:0], 0);
    assign mergeValid = saveS2;

endmodule

// File: design/accumulatorBank.sv
`timescale 1ns/1ps
`include "systolicCfg.svh"

module accumulatorBank (
    input  logic                clk,
    input  logic                rst_n,
    input  systolicPkg::phase_e phase,
    frameIf.consumer            frame,
    input  systolicPkg::addr_t  colLoad,
    input  systolicPkg::addr_t  rowLoad,
    input  systolicPkg::word_t  mergedWord,
    input  logic                mergeValid,
    output systolicPkg::word_t  acc0,
    output systolicPkg::word_t  acc1,
    output systolicPkg::word_t  acc2,
    output systolicPkg::word_t  acc3
);
    import systolicPkg::*;

    logic loadAny;

    assign loadAny = (phase == PH_LAST)
                   && (colLoad inside {`ADDR_LOAD01, `ADDR_LOAD23}
                       || rowLoad inside {`ADDR_LOAD01, `ADDR_LOAD23});

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            acc0 <= '0;
            acc1 <= '0;
            acc2 <= '0;
            acc3 <= '0;
        end else begin
            // Result arrives three cycles after its operand phase
            if (mergeValid) begin
                case (phase)
                    PH_LOAD1: acc0 <= mergedWord;
                    PH_LOAD2: acc1 <= mergedWord;
                    PH_LAST:  acc2 <= mergedWord;
                    default:  acc3 <= mergedWord;
                endcase
            end
            // Loads come last so they override the C2 merge
            if (loadAny) begin
                if (colLoad == `ADDR_LOAD01) begin
                    acc0 <= frame.colWord;
                end
                if (colLoad == `ADDR_LOAD23) begin
                    acc2 <= frame.colWord;
                end
                if (rowLoad == `ADDR_LOAD01) begin
                    acc1 <= frame.rowWord;
                end
                if (rowLoad == `ADDR_LOAD23) begin
                    acc3 <= frame.rowWord;
                end
            end
        end
    end

    // Outside of loads only the pipeline may change an accumulator
    assert property (@(posedge clk)
        $past(rst_n) && !$past(loadAny)
        && ({acc0, acc1, acc2, acc3} != $past({acc0, acc1, acc2, acc3}))
        |-> $past(mergeValid))
        else $error("accumulator changed without a valid merge");

endmodule

// File: design/systolicCell.sv
`timescale 1ns/1ps

module systolicCell (
    input  logic                 clk,
    input  logic                 rst_n,
    input  systolicPkg::nibble_t colIn,
    input  systolicPkg::nibble_t rowIn,
    input  logic                 colCtrlIn,
    input  logic                 rowCtrlIn,
    output systolicPkg::nibble_t colOut,
    output systolicPkg::nibble_t rowOut,
    output logic                 colCtrlOut,
    output logic                 rowCtrlOut
);
    import systolicPkg::*;

    phase_e phase;
    addr_t colLoad;
    addr_t rowLoad;
    logic save;
    word_t mergedWord;
    logic mergeValid;
    word_t acc0;
    word_t acc1;
    word_t acc2;
    word_t acc3;

    frameIf liveFrame ();   // Words arriving this block
    frameIf fwdFrame ();    // Words leaving during this block

    cellControl ctrl (
        .clk     (clk),
        .rst_n   (rst_n),
        .frame   (liveFrame),
        .fwdFrame(fwdFrame),
        .phase   (phase),
        .colLoad (colLoad),
        .rowLoad (rowLoad),
        .save    (save)
    );

    nibblePort port (
        .clk       (clk),
        .rst_n     (rst_n),
        .colIn     (colIn),
        .rowIn     (rowIn),
        .colCtrlIn (colCtrlIn),
        .rowCtrlIn (rowCtrlIn),
        .phase     (phase),
        .colLoad   (colLoad),
        .rowLoad   (rowLoad),
        .acc0      (acc0),
        .acc1      (acc1),
        .acc2      (acc2),
        .acc3      (acc3),
        .frame     (liveFrame),
        .fwdFrame  (fwdFrame),
        .colOut    (colOut),
        .rowOut    (rowOut),
        .colCtrlOut(colCtrlOut),
        .rowCtrlOut(rowCtrlOut)
    );

    productPipeline pipe (
        .clk       (clk),
        .rst_n     (rst_n),
        .phase     (phase),
        .save      (save),
        .frame     (liveFrame),
        .fwdFrame  (fwdFrame),
        .acc0      (acc0),
        .acc1      (acc1),
        .acc2      (acc2),
        .acc3      (acc3),
        .mergedWord(mergedWord),
        .mergeValid(mergeValid)
    );

    accumulatorBank accs (
        .clk       (clk),
        .rst_n     (rst_n),
        .phase     (phase),
        .frame     (liveFrame),
        .colLoad   (colLoad),
        .rowLoad   (rowLoad),
        .mergedWord(mergedWord),
        .mergeValid(mergeValid),
        .acc0      (acc0),
        .acc1      (acc1),
        .acc2      (acc2),
        .acc3      (acc3)
    );

endmodule

// File: testbench/tbClock.sv
`timescale 1ns/1ps

module tbClock (
    output logic clk
);
    localparam time HALF_PERIOD = 10ns;  // 20 ns period

    initial begin
        clk = 1'b0;
    end

    always begin
        #(HALF_PERIOD) clk = ~clk;
    end

endmodule

// File: testbench/systolicCellTb.sv
`timescale 1ns/1ps
`include "systolicCfg.svh"

module systolicCellTb;
    import systolicPkg::*;

    localparam string PATTERN_FILE = "testbench/cellPatterns.txt";
    localparam int MAX_CYCLES = 2000;
    localparam int OUT_LATENCY = 5;  // Edges from nibble 0 in to nibble 0 out

    logic clk;
    logic rst_n;
    nibble_t colIn;
    nibble_t rowIn;
    logic colCtrlIn;
    logic rowCtrlIn;
    nibble_t colOut;
    nibble_t rowOut;
    logic colCtrlOut;
    logic rowCtrlOut;

    word_t colInQ[$];
    word_t rowInQ[$];
    ctrl_t colCtrlQ[$];
    ctrl_t rowCtrlQ[$];
    word_t expColQ[$];
    word_t expRowQ[$];
    ctrl_t expColCtrlQ[$];
    ctrl_t expRowCtrlQ[$];

    word_t gotCol;
    word_t gotRow;
    ctrl_t gotColCtrl;
    ctrl_t gotRowCtrl;

    tbClock clockGen (
        .clk(clk)
    );

    systolicCell i_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .colIn     (colIn),
        .rowIn     (rowIn),
        .colCtrlIn (colCtrlIn),
        .rowCtrlIn (rowCtrlIn),
        .colOut    (colOut),
        .rowOut    (rowOut),
        .colCtrlOut(colCtrlOut),
        .rowCtrlOut(rowCtrlOut)
    );

    task automatic readPatterns();
        int fd;
        int fields;
        string line;
        logic [31:0] v[8];
        fd = $fopen(PATTERN_FILE, "r");
        if (fd == 0) begin
            $display("Could not open the pattern file %s", PATTERN_FILE);
            $display("Verification failed");
            $fatal(1);
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() > 0 && line[0] != "#") begin
                fields = $sscanf(line, "%h %h %h %h %h %h %h %h",
                                 v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7]);
                if (fields == 8) begin
                    colInQ.push_back(word_t'(v[0]));
                    rowInQ.push_back(word_t'(v[1]));
                    colCtrlQ.push_back(ctrl_t'(v[2]));
                    rowCtrlQ.push_back(ctrl_t'(v[3]));
                    expColQ.push_back(word_t'(v[4]));
                    expRowQ.push_back(word_t'(v[5]));
                    expColCtrlQ.push_back(ctrl_t'(v[6]));
                    expRowCtrlQ.push_back(ctrl_t'(v[7]));
                end
            end
        end
        $fclose(fd);
    endtask

    task automatic checkWord(input string name, input int blk, input word_t got,
                             input word_t exp);
        if (got !== exp) begin
            $display("ERROR: %s block %0d got 0x%h expected 0x%h", name, blk, got, exp);
            $display("Verification failed");
            $fatal(1);
        end
    endtask

    task automatic checkCtrl(input string name, input int blk, input ctrl_t got,
                             input ctrl_t exp);
        if (got !== exp) begin
            $display("ERROR: %s block %0d got 0x%h expected 0x%h", name, blk, got, exp);
            $display("Verification failed");
            $fatal(1);
        end
    endtask

    // Slot n carries nibble n%4 of block n/4, MSB first
    task automatic driveSlot(input int n);
        int blk;
        int k;
        blk = n / `BLOCK_LEN;
        k = n % `BLOCK_LEN;
        if (blk < colInQ.size()) begin
            colIn <= colInQ[blk][15-4*k -: 4];
            rowIn <= rowInQ[blk][15-4*k -: 4];
            colCtrlIn <= colCtrlQ[blk][3-k];
            rowCtrlIn <= rowCtrlQ[blk][3-k];
        end else begin
            colIn <= '0;
            rowIn <= '0;
            colCtrlIn <= 1'b0;
            rowCtrlIn <= 1'b0;
        end
    endtask

    task automatic collectSlot(input int n);
        int blk;
        int k;
        if (n >= OUT_LATENCY) begin
            blk = (n - OUT_LATENCY) / `BLOCK_LEN;
            k = (n - OUT_LATENCY) % `BLOCK_LEN;
            gotCol = {gotCol[11:0], colOut};
            gotRow = {gotRow[11:0], rowOut};
            gotColCtrl = {gotColCtrl[2:0], colCtrlOut};
            gotRowCtrl = {gotRowCtrl[2:0], rowCtrlOut};
            if (k == `BLOCK_LEN - 1 && blk < expColQ.size()) begin
                checkWord("colOut", blk, gotCol, expColQ[blk]);
                checkWord("rowOut", blk, gotRow, expRowQ[blk]);
                checkCtrl("colCtrlOut", blk, gotColCtrl, expColCtrlQ[blk]);
                checkCtrl("rowCtrlOut", blk, gotRowCtrl, expRowCtrlQ[blk]);
            end
        end
    endtask

    initial begin : watchdog
        for (int i = 0; i < MAX_CYCLES; i++) begin
            @(posedge clk);
        end
        $display("Simulation ran too long without finishing");
        $display("Verification failed");
        $fatal(1);
    end

    initial begin
        int totalSlots;
        rst_n = 1'b0;
        colIn = '0;
        rowIn = '0;
        colCtrlIn = 1'b0;
        rowCtrlIn = 1'b0;
        gotCol = '0;
        gotRow = '0;
        gotColCtrl = '0;
        gotRowCtrl = '0;
        readPatterns();
        if (colInQ.size() == 0) begin
            $display("The pattern file holds no blocks");
            $display("Verification failed");
            $fatal(1);
        end
        totalSlots = `BLOCK_LEN * colInQ.size() + OUT_LATENCY;

        // Reset is low at four rising edges, released on the fourth
        for (int i = 0; i < 3; i++) begin
            @(posedge clk);
        end
        for (int n = 0; n < totalSlots; n++) begin
            @(posedge clk);
            if (n == 0) begin
                rst_n <= 1'b1;
            end
            driveSlot(n);
            @(negedge clk);  // Outputs settled
            collectSlot(n);
        end

        $display("Verification passed");
        $finish;
    end

endmodule

// File: testbench/cellPatterns.txt
# colIn rowIn colCtrl rowCtrl | expected colOut rowOut colCtrlOut rowCtrlOut (hex)
# One line per block, outputs appear one block later
1234 ABCD 1 2 1234 ABCD 1 2
0F0F 3C3C 8 B 0000 0000 8 B
5A5A A5A5 C D 0000 0000 C D
3EC1 3F42 4 6 3EC1 3F42 4 6
7777 8888 3 0 7777 8888 3 0
0000 0000 9 A 0A0F 2D1C 9 A
0000 FFFF E F 485A BBA5 E F
7D7C 803C 4 5 7D7C 803C 4 5
DEAD BEEF 0 1 DEAD BEEF 0 1
0000 0000 8 8 3001 3001 8 8
0000 0000 C C 3001 CFFF C C
7B07 7B87 5 7 7B07 7B87 5 7
0123 4567 2 3 0123 4567 2 3
1357 2468 A 9 3000 1820 A 9
9BDF ACE0 D E 1820 0000 D E
0706 231D 6 4 0706 231D 6 4
FFFF 0001 1 0 FFFF 0001 1 0
1111 2222 8 B 134F 247D 8 B
3333 4444 F C 9BD6 ACE8 F C
3C3C 3C3C 4 0 3C3C 3C3C 4 0
4000 4000 0 5 4000 4000 0 5
0000 0000 8 8 1111 2222 8 8
0000 0000 C C 3333 4444 C C

// File: list.f
+incdir+include
design/systolicPkg.sv
design/frameIf.sv
design/cellControl.sv
design/nibblePort.sv
design/fp8Multiplier.sv
design/productPipeline.sv
design/accumulatorBank.sv
design/systolicCell.sv
testbench/tbClock.sv
testbench/systolicCellTb.sv

// File: run.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module systolicCellTb -f list.f -o simv

output=$(./obj_dir/simv 2>&1) || true
echo "$output"

if echo "$output" | grep -q "Verification passed"; then
    exit 0
else
    exit 1
fi
